//--- gbt_link_test.f
logic/gbt_link_pkg.sv
logic/los_reset_filter.sv
logic/feed_pattern_gen.sv
logic/feed_pattern_check.sv
logic/link_status_monitor.sv
logic/gbt_link_test.sv
test/gbt_link_test_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the gbt link self-test testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module gbt_link_test_tb \
   -f gbt_link_test.f \
   -o gbt_link_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/gbt_link_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

echo "simulation finished without failures"
exit 0

//--- test/gbt_link_test_tb.sv
// gbt link self-test testbench with clock, reset, corrupting loopback and checks
module gbt_link_test_tb;

   logic                               gbt_data_x;
   logic                               SFP_reset;
   logic                               gbt_los;
   logic                               txready;
   logic                               rxready;
   logic [gbt_link_pkg::FEED_W-1:0]    rx_data;
   logic [gbt_link_pkg::FEED_W-1:0]    tx_data;
   logic                               link_up;
   gbt_link_pkg::link_state_t          link_state;
   logic [gbt_link_pkg::ERR_CNT_W-1:0] error_count;

   // first two loopback stages ahead of rx_data
   logic [gbt_link_pkg::FEED_W-1:0]    loop_dly [0:1];
   // corruption requests from the stimulus
   int unsigned                        corrupt_req;
   // requests the loopback has applied
   int unsigned                        corrupt_done;
   // bit to flip in the next corrupted word
   logic [gbt_link_pkg::FEED_W-1:0]    corrupt_mask;

   gbt_link_test i_dut (
      .gbt_data_x  (gbt_data_x),
      .SFP_reset   (SFP_reset),
      .gbt_los     (gbt_los),
      .txready     (txready),
      .rxready     (rxready),
      .rx_data     (rx_data),
      .tx_data     (tx_data),
      .link_up     (link_up),
      .link_state  (link_state),
      .error_count (error_count)
   );

   initial begin
      gbt_data_x = 1'b0;
      forever #10 gbt_data_x = ~gbt_data_x;
   end

   // ------------------------------
   // error reporting
   // ------------------------------

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic value_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      abort_run();
   endtask

   task automatic rule_broken(input string what);
      $display("Error: %s", what);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      abort_run();
   endtask

   // ------------------------------
   // three-cycle loopback
   // ------------------------------

   initial begin
      rx_data      <= '0;
      loop_dly[0]  <= '0;
      loop_dly[1]  <= '0;
      corrupt_done <= 0;
      forever begin
         @(posedge gbt_data_x);
         loop_dly[0] <= tx_data;
         loop_dly[1] <= loop_dly[0];
         if (corrupt_req != corrupt_done) begin
            // one bit flipped in exactly one word
            rx_data      <= loop_dly[1] ^ corrupt_mask;
            corrupt_done <= corrupt_req;
         end else begin
            rx_data <= loop_dly[1];
         end
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------

   task automatic corrupt_one_word();
      @(posedge gbt_data_x);
      corrupt_mask <= gbt_link_pkg::FEED_W'(1) << ($urandom % gbt_link_pkg::FEED_W);
      corrupt_req  <= corrupt_req + 1;
   endtask

   task automatic wait_link_up(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while ((link_up !== level) && (n < limit)) begin
         @(negedge gbt_data_x);
         n++;
      end
      if (link_up !== level) begin
         report_timeout(what);
      end
   endtask

   task automatic wait_link_state(input gbt_link_pkg::link_state_t st, input int limit,
                                  input string what);
      int n;
      n = 0;
      while ((link_state !== st) && (n < limit)) begin
         @(negedge gbt_data_x);
         n++;
      end
      if (link_state !== st) begin
         report_timeout(what);
      end
   endtask

   // error count only moves up once out of reset
   assert property (@(posedge gbt_data_x) disable iff (SFP_reset)
      error_count >= $past(error_count))
      else rule_broken("error_count went down without a reset");

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      int                                 n;
      int                                 gap;
      logic [gbt_link_pkg::FEED_W-1:0]    model;
      logic [gbt_link_pkg::ERR_CNT_W-1:0] err_before;
      void'($urandom(32'hbe8c));
      SFP_reset    <= 1'b1;
      gbt_los      <= 1'b0;
      txready      <= 1'b0;
      rxready      <= 1'b0;
      corrupt_req  <= 0;
      corrupt_mask <= '0;

      // reset values while reset is still held
      repeat (9) @(posedge gbt_data_x);
      @(negedge gbt_data_x);
      assert (tx_data == '0) else value_mismatch("reset_tx_data", 64'(0), tx_data);
      assert (!link_up) else value_mismatch("reset_link_up", 64'(0), 64'(link_up));
      assert (error_count == '0)
         else value_mismatch("reset_error_count", 64'(0), 64'(error_count));
      assert (link_state == gbt_link_pkg::st_down)
         else value_mismatch("reset_link_state", 64'(gbt_link_pkg::st_down), 64'(link_state));
      @(posedge gbt_data_x);
      SFP_reset <= 1'b0;
      txready   <= 1'b1;

      // counting with back-pressure and the return path idle
      @(negedge gbt_data_x);
      assert (tx_data == '0) else value_mismatch("count_start", 64'(0), tx_data);
      n = 0;
      while ((tx_data == '0) && (n < 40)) begin
         @(negedge gbt_data_x);
         n++;
      end
      if (tx_data == '0) report_timeout("tx_data to leave zero after reset");
      // first step out of zero
      assert (tx_data == 64'(1)) else value_mismatch("count_first", 64'(1), tx_data);
      model = 64'(1) + 64'(txready);
      repeat (48) begin
         @(posedge gbt_data_x);
         txready <= (($urandom % 3) != 0);
         @(negedge gbt_data_x);
         assert (tx_data == model) else value_mismatch("count", model, tx_data);
         model = model + 64'(txready);
      end

      // lock over the closed loopback
      @(posedge gbt_data_x);
      txready <= 1'b1;
      rxready <= 1'b1;
      wait_link_up(1'b1, 60, "link_up after closing the loopback");
      assert (link_state == gbt_link_pkg::st_up)
         else value_mismatch("lock_state", 64'(gbt_link_pkg::st_up), 64'(link_state));
      repeat (16) begin
         @(negedge gbt_data_x);
         assert (link_up) else value_mismatch("lock_hold", 64'(1), 64'(link_up));
         assert (error_count == '0)
            else value_mismatch("lock_errors", 64'(0), 64'(error_count));
      end

      // single corrupted word
      err_before = error_count;
      corrupt_one_word();
      wait_link_up(1'b0, 20, "link_up to fall after a corrupted word");
      wait_link_up(1'b1, 60, "relock after a corrupted word");
      assert (error_count == gbt_link_pkg::ERR_CNT_W'(err_before + 1))
         else value_mismatch("single_error", 64'(err_before + 1), 64'(error_count));

      // silent relock after an rxready gap
      err_before = error_count;
      gap = 2 + ($urandom % 10);
      @(posedge gbt_data_x);
      rxready <= 1'b0;
      repeat (gap) @(posedge gbt_data_x);
      rxready <= 1'b1;
      wait_link_up(1'b0, 20, "link_up to fall during the rxready gap");
      wait_link_up(1'b1, 60, "relock after the rxready gap");
      assert (error_count == err_before)
         else value_mismatch("resync", 64'(err_before), 64'(error_count));

      // short los pulse is filtered out
      @(posedge gbt_data_x);
      gbt_los <= 1'b1;
      repeat (gbt_link_pkg::LOS_FILTER_LEN - 1) @(posedge gbt_data_x);
      gbt_los <= 1'b0;
      @(negedge gbt_data_x);
      model = tx_data;
      repeat (12) begin
         @(negedge gbt_data_x);
         model = model + 64'(1);
         assert (tx_data == model)
            else value_mismatch("los_short_count", model, tx_data);
         assert (link_up) else value_mismatch("los_short_link", 64'(1), 64'(link_up));
      end

      // long los takes the link down and keeps the errors
      err_before = error_count;
      @(posedge gbt_data_x);
      gbt_los <= 1'b1;
      wait_link_state(gbt_link_pkg::st_down,
                      gbt_link_pkg::SYNC_STAGES + gbt_link_pkg::LOS_FILTER_LEN + 4,
                      "link_state st_down on a long los");
      assert (tx_data == '0) else value_mismatch("los_long_tx", 64'(0), tx_data);
      @(posedge gbt_data_x);
      gbt_los <= 1'b0;
      wait_link_up(1'b1, 80, "relock after los clears");
      assert (error_count == err_before)
         else value_mismatch("los_long_errors", 64'(err_before), 64'(error_count));

      // drive the counter into saturation
      n = 0;
      while ((error_count != '1) && (n < 300)) begin
         err_before = error_count;
         corrupt_one_word();
         wait_link_up(1'b0, 20, "link_up to fall while saturating");
         wait_link_up(1'b1, 60, "relock while saturating");
         assert (error_count == gbt_link_pkg::ERR_CNT_W'(err_before + 1))
            else value_mismatch("saturate_step", 64'(err_before + 1), 64'(error_count));
         n++;
      end
      assert (error_count == '1)
         else value_mismatch("saturate", 64'({gbt_link_pkg::ERR_CNT_W{1'b1}}),
                             64'(error_count));
      // one more break must not wrap the count
      corrupt_one_word();
      wait_link_up(1'b0, 20, "link_up to fall after saturation");
      wait_link_up(1'b1, 60, "relock after saturation");
      assert (error_count == '1)
         else value_mismatch("saturate_hold", 64'({gbt_link_pkg::ERR_CNT_W{1'b1}}),
                             64'(error_count));

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- logic/gbt_link_test.sv
// top level of the gbt link self-test: los filter, feed generator, checker and monitor
module gbt_link_test (
   input  logic                               gbt_data_x,
   input  logic                               SFP_reset,
   input  logic                               gbt_los,
   input  logic                               txready,
   input  logic                               rxready,
   input  logic [gbt_link_pkg::FEED_W-1:0]    rx_data,
   output logic [gbt_link_pkg::FEED_W-1:0]    tx_data,
   output logic                               link_up,
   output gbt_link_pkg::link_state_t          link_state,
   output logic [gbt_link_pkg::ERR_CNT_W-1:0] error_count
);

   // filtered los, clears both directions
   logic link_down;
   // generator is sending
   logic tx_active;
   // checker has the stream
   logic locked;
   // one pulse per broken word
   logic seq_error;

   // ------------------------------
   // los filter
   // ------------------------------

   los_reset_filter i_los_filter (
      .gbt_data_x (gbt_data_x),
      .SFP_reset  (SFP_reset),
      .gbt_los    (gbt_los),
      .link_down  (link_down)
   );

   // ------------------------------
   // transmit and receive sides
   // ------------------------------

   feed_pattern_gen i_feed_gen (
      .gbt_data_x (gbt_data_x),
      .SFP_reset  (SFP_reset),
      .link_down  (link_down),
      .txready    (txready),
      .tx_data    (tx_data),
      .tx_active  (tx_active)
   );

   feed_pattern_check i_feed_check (
      .gbt_data_x (gbt_data_x),
      .SFP_reset  (SFP_reset),
      .link_down  (link_down),
      .rxready    (rxready),
      .rx_data    (rx_data),
      .locked     (locked),
      .seq_error  (seq_error)
   );

   // status combines both sides
   link_status_monitor i_status (
      .gbt_data_x  (gbt_data_x),
      .SFP_reset   (SFP_reset),
      .link_down   (link_down),
      .tx_active   (tx_active),
      .locked      (locked),
      .seq_error   (seq_error),
      .link_state  (link_state),
      .link_up     (link_up),
      .error_count (error_count)
   );

endmodule

//--- logic/link_status_monitor.sv
// link state FSM, link-up level and saturating sequence error counter
module link_status_monitor (
   input  logic                               gbt_data_x,
   input  logic                               SFP_reset,
   input  logic                               link_down,
   input  logic                               tx_active,
   input  logic                               locked,
   input  logic                               seq_error,
   output gbt_link_pkg::link_state_t          link_state,
   output logic                               link_up,
   output logic [gbt_link_pkg::ERR_CNT_W-1:0] error_count
);

   // state for the next cycle
   gbt_link_pkg::link_state_t state_nxt;

   // ------------------------------
   // link state
   // ------------------------------

   always_comb begin
      if (link_down) begin
         // no optical signal
         state_nxt = gbt_link_pkg::st_down;
      end else if (tx_active && locked) begin
         // both directions good
         state_nxt = gbt_link_pkg::st_up;
      end else if (tx_active) begin
         // sending, but the return stream is not locked yet
         state_nxt = gbt_link_pkg::st_tx_only;
      end else begin
         // signal present but transmitter idle
         // counts as down for the link
         state_nxt = gbt_link_pkg::st_down;
      end
   end

   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         link_state <= gbt_link_pkg::st_down;
      end else begin
         link_state <= state_nxt;
      end
   end

   // up only in the full state
   assign link_up = (link_state == gbt_link_pkg::st_up);

   // ------------------------------
   // error counter
   // ------------------------------

   // keeps history across relocks and los events
   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         error_count <= '0;
      end else if (seq_error && (error_count != '1)) begin
         error_count <= error_count + gbt_link_pkg::ERR_CNT_W'(1);
      end
      // at all ones further errors are lost
   end

endmodule

//--- logic/feed_pattern_check.sv
// receive-side checker that locks onto the counter stream and flags sequence breaks
module feed_pattern_check (
   input  logic                            gbt_data_x,
   input  logic                            SFP_reset,
   input  logic                            link_down,
   input  logic                            rxready,
   input  logic [gbt_link_pkg::FEED_W-1:0] rx_data,
   output logic                            locked,
   output logic                            seq_error
);

   // checker FSM state
   gbt_link_pkg::check_state_t           state;
   // next word the stream should carry
   logic [gbt_link_pkg::FEED_W-1:0]      expected;
   // expected holds a real base word
   logic                                 base_valid;
   // consecutive matching words while hunting
   logic [gbt_link_pkg::LOCK_CNT_W-1:0]  match_cnt;
   // current word equals the prediction
   logic                                 word_match;

   assign word_match = base_valid && (rx_data == expected);

   // ------------------------------
   // expected word
   // ------------------------------

   // each valid word predicts its successor
   always_ff @(posedge gbt_data_x) begin
      if (rxready) begin
         expected <= rx_data + gbt_link_pkg::FEED_W'(1);
      end
   end

   // ------------------------------
   // lock FSM
   // ------------------------------

   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         state      <= gbt_link_pkg::st_hunt;
         base_valid <= 1'b0;
         match_cnt  <= '0;
         seq_error  <= 1'b0;
      end else if (link_down || !rxready) begin
         // stream gap or no signal starts the hunt over quietly
         state      <= gbt_link_pkg::st_hunt;
         base_valid <= 1'b0;
         match_cnt  <= '0;
         seq_error  <= 1'b0;
      end else begin
         // from here on rx_data is valid this cycle
         base_valid <= 1'b1;
         seq_error  <= 1'b0;
         case (state)
            gbt_link_pkg::st_hunt: begin
               if (!word_match) begin
                  // sequence broken so this word is the new base
                  match_cnt <= '0;
               end else if (match_cnt ==
                  gbt_link_pkg::LOCK_CNT_W'(gbt_link_pkg::LOCK_COUNT - 1)) begin
                  state     <= gbt_link_pkg::st_locked;
                  match_cnt <= '0;
               end else begin
                  match_cnt <= match_cnt + gbt_link_pkg::LOCK_CNT_W'(1);
               end
            end
            gbt_link_pkg::st_locked: begin
               if (!word_match) begin
                  // one pulse per break before hunting from this word
                  seq_error <= 1'b1;
                  state     <= gbt_link_pkg::st_hunt;
                  match_cnt <= '0;
               end
            end
         endcase
      end
   end

   // lock is the state itself and follows the deciding word by one cycle
   assign locked = (state == gbt_link_pkg::st_locked);

endmodule

//--- logic/feed_pattern_gen.sv
// free-running 64-bit feed counter driving the transmitted motor data word
module feed_pattern_gen (
   input  logic                            gbt_data_x,
   input  logic                            SFP_reset,
   input  logic                            link_down,
   input  logic                            txready,
   output logic [gbt_link_pkg::FEED_W-1:0] tx_data,
   output logic                            tx_active
);

   // ------------------------------
   // feed counter
   // ------------------------------

   // the counter value goes out as-is as the motor data word
   // the far end only has to check for a step of one
   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         tx_data <= '0;
      end else if (link_down) begin
         // hold at zero while there is no optical signal
         tx_data <= '0;
      end else if (txready) begin
         tx_data <= tx_data + gbt_link_pkg::FEED_W'(1);
      end
      // txready low keeps the word, no skipped values
   end

   // ------------------------------
   // activity flag
   // ------------------------------

   // tells the monitor the transmit side is really sending
   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         tx_active <= 1'b0;
      end else begin
         // txready registered, masked by link_down
         tx_active <= txready & ~link_down;
      end
   end

endmodule

//--- logic/los_reset_filter.sv
// sfp loss-of-signal synchronizer and glitch filter producing the link-down level
module los_reset_filter (
   input  logic gbt_data_x,
   input  logic SFP_reset,
   input  logic gbt_los,
   output logic link_down
);

   // synchronizer chain, oldest stage at the top
   logic [gbt_link_pkg::SYNC_STAGES-1:0] los_sync;
   // synchronized los level
   logic                                 los_level;
   // cycles the synchronized level has differed from link_down
   logic [gbt_link_pkg::LOS_CNT_W-1:0]   stable_cnt;

   // ------------------------------
   // synchronizer
   // ------------------------------

   // gbt_los comes straight off the sfp cage, async to gbt_data_x
   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         // start as if the signal were lost
         los_sync <= '1;
      end else begin
         los_sync <= {los_sync[gbt_link_pkg::SYNC_STAGES-2:0], gbt_los};
      end
   end

   assign los_level = los_sync[gbt_link_pkg::SYNC_STAGES-1];

   // ------------------------------
   // stability filter
   // ------------------------------

   always_ff @(posedge gbt_data_x) begin
      if (SFP_reset) begin
         // link is down until los has been low long enough
         link_down  <= 1'b1;
         stable_cnt <= '0;
      end else if (los_level != link_down) begin
         if (stable_cnt ==
             gbt_link_pkg::LOS_CNT_W'(gbt_link_pkg::LOS_FILTER_LEN - 1)) begin
            // new level held for the full window
            link_down  <= los_level;
            stable_cnt <= '0;
         end else begin
            stable_cnt <= stable_cnt + gbt_link_pkg::LOS_CNT_W'(1);
         end
      end else begin
         // level agrees again, any short pulse is dropped
         stable_cnt <= '0;
      end
   end

endmodule

//--- logic/gbt_link_pkg.sv
// widths, filter and lock lengths, checker and link state enums for the gbt link self-test
package gbt_link_pkg;

   // ------------------------------
   // data path widths
   // ------------------------------

   // motor data word and feed counter
   localparam int FEED_W = 64;

   // error counter, saturates at all ones
   localparam int ERR_CNT_W = 8;

   // ------------------------------
   // loss of signal filtering
   // ------------------------------

   // flip-flops in the gbt_los synchronizer
   localparam int SYNC_STAGES = 2;

   // cycles a new los level must hold before link_down follows
   localparam int LOS_FILTER_LEN = 4;

   // stability counter, sized to reach LOS_FILTER_LEN
   localparam int LOS_CNT_W = $clog2(LOS_FILTER_LEN + 1);

   // ------------------------------
   // checker lock
   // ------------------------------

   // in-sequence words needed before lock
   localparam int LOCK_COUNT = 4;

   // match run counter, sized to reach LOCK_COUNT
   localparam int LOCK_CNT_W = $clog2(LOCK_COUNT + 1);

   // checker FSM
   // hunt takes every valid word as a new base
   typedef enum logic {
      st_hunt   = 1'b0,
      st_locked = 1'b1
   } check_state_t;

   // link state as seen by the monitor
   typedef enum logic [1:0] {
      st_down    = 2'd0,
      st_tx_only = 2'd1,
      st_up      = 2'd2
   } link_state_t;

endpackage
